// ==== verilog/ec_field_pkg.sv ====
//======================================================================
// Prime field definitions
//======================================================================
package ec_field_pkg;

  // Mersenne prime 2^13 - 1
  localparam int P       = 8191;
  localparam int FE_BITS = 13;
  localparam int MUL_LAT = 3;

  typedef logic [FE_BITS-1:0] fe_t;

  // Local additions used by both point units
  function automatic fe_t fe_add(fe_t a, fe_t b);
    logic [FE_BITS:0] s;
    s = a + b;
    return (s >= P) ? fe_t'(s - P) : fe_t'(s);
  endfunction

  function automatic fe_t fe_sub(fe_t a, fe_t b);
    return (a >= b) ? fe_t'(a - b) : fe_t'(a + P - b);
  endfunction

endpackage

// ==== verilog/ec_curve_pkg.sv ====
//======================================================================
// Curve and point definitions
//======================================================================
package ec_curve_pkg;

  // Coefficient a of y^2 = x^3 + a*x + b
  localparam ec_field_pkg::fe_t CURVE_A = 13'd2;

  // Scalar width
  localparam int K_BITS = 16;

  // Jacobian point, infinity is any point with z == 0
  typedef struct packed {
    ec_field_pkg::fe_t x;
    ec_field_pkg::fe_t y;
    ec_field_pkg::fe_t z;
  } point_t;

endpackage

// ==== verilog/fp_mult.sv ====
//======================================================================
// Pipelined modular multiplier
//======================================================================
module fp_mult (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_val,
  input  ec_field_pkg::fe_t i_a,
  input  ec_field_pkg::fe_t i_b,
  input  logic              i_tag,
  output logic              o_val,
  output ec_field_pkg::fe_t o_res,
  output logic              o_tag
);
  import ec_field_pkg::*;

  logic [2*FE_BITS-1:0] prod;
  logic [FE_BITS:0]     fold;
  logic [FE_BITS:0]     fold2;
  fe_t                  res_q;
  logic [MUL_LAT-1:0]   val_sr;
  logic [MUL_LAT-1:0]   tag_sr;

  // Second fold adds the carry back in, since 2^13 = 1 mod P
  assign fold2 = fold[FE_BITS-1:0] + fold[FE_BITS];

  always_ff @(posedge i_clk) begin
    prod   <= i_a * i_b;
    fold   <= prod[FE_BITS-1:0] + prod[2*FE_BITS-1:FE_BITS];
    res_q  <= (fold2 >= P) ? fe_t'(fold2 - P) : fe_t'(fold2);
    tag_sr <= {tag_sr[MUL_LAT-2:0], i_tag};
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_sr <= '0;
    end else begin
      val_sr <= {val_sr[MUL_LAT-2:0], i_val};
    end
  end

  assign o_val = val_sr[MUL_LAT-1];
  assign o_tag = tag_sr[MUL_LAT-1];
  assign o_res = res_q;

  // The reduction only holds for reduced operands
  assert property (@(posedge i_clk) disable iff (i_rst)
    i_val |-> (i_a < P && i_b < P));

endmodule

// ==== verilog/mult_arbiter.sv ====
//======================================================================
// Multiplier arbiter
//======================================================================
module mult_arbiter (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [1:0]        i_req,
  input  ec_field_pkg::fe_t i_a0,
  input  ec_field_pkg::fe_t i_b0,
  input  ec_field_pkg::fe_t i_a1,
  input  ec_field_pkg::fe_t i_b1,
  output logic [1:0]        o_gnt,
  output logic              o_val,
  output ec_field_pkg::fe_t o_a,
  output ec_field_pkg::fe_t o_b,
  output logic              o_tag,
  input  logic              i_val,
  input  ec_field_pkg::fe_t i_res,
  input  logic              i_tag,
  output logic [1:0]        o_rval,
  output ec_field_pkg::fe_t o_res
);

  // Requester 1 has priority when set
  logic prio;

  always_comb begin
    o_gnt = 2'b00;
    if (i_req[0] && (!i_req[1] || !prio)) begin
      o_gnt = 2'b01;
    end else if (i_req[1]) begin
      o_gnt = 2'b10;
    end
  end

  assign o_val = |o_gnt;
  assign o_tag = o_gnt[1];
  assign o_a   = o_gnt[1] ? i_a1 : i_a0;
  assign o_b   = o_gnt[1] ? i_b1 : i_b0;

  // Pass priority to the other unit after each grant
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      prio <= 1'b0;
    end else if (o_gnt[0]) begin
      prio <= 1'b1;
    end else if (o_gnt[1]) begin
      prio <= 1'b0;
    end
  end

  // Products return to the unit named by the tag
  assign o_rval = {i_val & i_tag, i_val & ~i_tag};
  assign o_res  = i_res;

  // A unit left waiting gets the next grant alone
  assert property (@(posedge i_clk) disable iff (i_rst)
    (o_gnt[0] && i_req[1]) |=> (o_gnt == 2'b10));
  assert property (@(posedge i_clk) disable iff (i_rst)
    (o_gnt[1] && i_req[0]) |=> (o_gnt == 2'b01));

endmodule

// ==== verilog/point_dbl.sv ====
//======================================================================
// Jacobian point doubling
//======================================================================
module point_dbl (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_go,
  input  ec_curve_pkg::point_t i_p,
  output ec_curve_pkg::point_t o_p,
  output logic                 o_done,
  output logic                 o_mreq,
  output ec_field_pkg::fe_t    o_ma,
  output ec_field_pkg::fe_t    o_mb,
  input  logic                 i_mgnt,
  input  logic                 i_mval,
  input  ec_field_pkg::fe_t    i_mres
);
  import ec_field_pkg::*;
  import ec_curve_pkg::*;

  localparam int LAST = 9;

  point_t     p;
  fe_t        t0, t1, t2;
  fe_t        res2, res4, res8;
  logic [3:0] step;

  assign o_p  = p;
  assign res2 = fe_add(i_mres, i_mres);
  assign res4 = fe_add(res2, res2);
  assign res8 = fe_add(res4, res4);

  // Operands per step, held stable while the request waits
  always_comb begin
    case (step)
      4'd0:    begin o_ma = p.x;     o_mb = p.x; end
      4'd1:    begin o_ma = p.y;     o_mb = p.y; end
      4'd2:    begin o_ma = p.z;     o_mb = p.z; end
      4'd3:    begin o_ma = p.y;     o_mb = p.z; end
      4'd4:    begin o_ma = t1;      o_mb = t1;  end
      4'd5:    begin o_ma = p.x;     o_mb = t1;  end
      4'd6:    begin o_ma = t2;      o_mb = t2;  end
      4'd7:    begin o_ma = CURVE_A; o_mb = t2;  end
      4'd8:    begin o_ma = t0;      o_mb = t0;  end
      default: begin o_ma = t0;      o_mb = fe_sub(t1, p.x); end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_go) begin
      p <= i_p;
    end else if (i_mval) begin
      case (step)
        4'd0: t0 <= i_mres;
        4'd1: t1 <= i_mres;
        4'd2: t2 <= i_mres;
        // Z3 = 2*Y*Z
        4'd3: p.z <= res2;
        // y holds 8*Y^4 until the last step
        4'd4: p.y <= res8;
        // S = 4*X*Y^2
        4'd5: t1 <= res4;
        4'd6: t2 <= i_mres;
        // M = 3*X^2 + a*Z^4
        4'd7: t0 <= fe_add(fe_add(fe_add(t0, t0), t0), i_mres);
        4'd8: p.x <= fe_sub(i_mres, fe_add(t1, t1));
        default: p.y <= fe_sub(i_mres, p.y);
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      step   <= '0;
      o_mreq <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_go) begin
        step <= '0;
        // Doubling infinity stays at infinity
        if (i_p.z == '0) begin
          o_done <= 1'b1;
        end else begin
          o_mreq <= 1'b1;
        end
      end
      if (i_mgnt) begin
        o_mreq <= 1'b0;
      end
      if (i_mval) begin
        step <= step + 4'd1;
        if (step == LAST) begin
          o_done <= 1'b1;
        end else begin
          o_mreq <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/point_add.sv ====
//======================================================================
// Jacobian point addition
//======================================================================
module point_add (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_go,
  input  ec_curve_pkg::point_t i_p1,
  input  ec_curve_pkg::point_t i_p2,
  output ec_curve_pkg::point_t o_p,
  output logic                 o_done,
  output logic                 o_same,
  output logic                 o_mreq,
  output ec_field_pkg::fe_t    o_ma,
  output ec_field_pkg::fe_t    o_mb,
  input  logic                 i_mgnt,
  input  logic                 i_mval,
  input  ec_field_pkg::fe_t    i_mres
);
  import ec_field_pkg::*;
  import ec_curve_pkg::*;

  localparam int LAST = 15;
  localparam int HR_STEP = 7;

  point_t     p1, p2;
  fe_t        t0, t1, t2, t3;
  fe_t        h, r;
  logic [3:0] step;

  assign o_p = p1;

  // H = U2 - U1 and R = S2 - S1, valid on the S2 product
  assign h = fe_sub(t3, t2);
  assign r = fe_sub(i_mres, t1);

  always_comb begin
    case (step)
      4'd0:    begin o_ma = p1.z; o_mb = p1.z; end
      4'd1:    begin o_ma = p2.z; o_mb = p2.z; end
      4'd2:    begin o_ma = p1.x; o_mb = t1;   end
      4'd3:    begin o_ma = p2.x; o_mb = t0;   end
      4'd4:    begin o_ma = p2.z; o_mb = t1;   end
      4'd5:    begin o_ma = p1.z; o_mb = t0;   end
      4'd6:    begin o_ma = p1.y; o_mb = t1;   end
      4'd7:    begin o_ma = p2.y; o_mb = t0;   end
      4'd8:    begin o_ma = p1.z; o_mb = p2.z; end
      4'd9:    begin o_ma = p1.z; o_mb = t3;   end
      4'd10:   begin o_ma = t3;   o_mb = t3;   end
      4'd11:   begin o_ma = t3;   o_mb = p2.x; end
      4'd12:   begin o_ma = t2;   o_mb = p2.x; end
      4'd13:   begin o_ma = t0;   o_mb = t0;   end
      4'd14:   begin o_ma = t1;   o_mb = t3;   end
      default: begin o_ma = t0;   o_mb = fe_sub(t2, p1.x); end
    endcase
  end

  // t0..t3 end up as R, S1, U1 and H; p2.x is reused for H^2
  always_ff @(posedge i_clk) begin
    if (i_go) begin
      p1 <= (i_p1.z == '0) ? i_p2 : i_p1;
      p2 <= i_p2;
    end else if (i_mval) begin
      case (step)
        4'd0, 4'd5: t0 <= i_mres;
        4'd1, 4'd4, 4'd6, 4'd14: t1 <= i_mres;
        4'd2, 4'd12: t2 <= i_mres;
        4'd3, 4'd11: t3 <= i_mres;
        4'd7: begin
          t0 <= r;
          t3 <= h;
        end
        4'd8, 4'd9: p1.z <= i_mres;
        4'd10: p2.x <= i_mres;
        // X3 = R^2 - H^3 - 2*V
        4'd13: p1.x <= fe_sub(fe_sub(i_mres, t3), fe_add(t2, t2));
        default: p1.y <= fe_sub(i_mres, t1);
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      step   <= '0;
      o_mreq <= 1'b0;
      o_done <= 1'b0;
      o_same <= 1'b0;
    end else begin
      o_done <= 1'b0;
      o_same <= 1'b0;
      if (i_go) begin
        step <= '0;
        if (i_p1.z == '0 || i_p2.z == '0) begin
          o_done <= 1'b1;
        end else begin
          o_mreq <= 1'b1;
        end
      end
      if (i_mgnt) begin
        o_mreq <= 1'b0;
      end
      if (i_mval) begin
        step <= step + 4'd1;
        if (step == HR_STEP && h == '0 && r == '0) begin
          o_same <= 1'b1;
        end else if (step == LAST) begin
          o_done <= 1'b1;
        end else begin
          o_mreq <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/point_mult_ctrl.sv ====
//======================================================================
// Double-and-add control
//======================================================================
module point_mult_ctrl (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_start,
  input  logic                            i_add_start,
  input  logic [ec_curve_pkg::K_BITS-1:0] i_k,
  input  ec_curve_pkg::point_t            i_p,
  input  ec_curve_pkg::point_t            i_p2,
  output logic                            o_dbl_go,
  output ec_curve_pkg::point_t            o_dbl_p,
  input  logic                            i_dbl_done,
  input  ec_curve_pkg::point_t            i_dbl_p,
  output logic                            o_add_go,
  output ec_curve_pkg::point_t            o_add_p1,
  output ec_curve_pkg::point_t            o_add_p2,
  input  logic                            i_add_done,
  input  logic                            i_add_same,
  input  ec_curve_pkg::point_t            i_add_p,
  output ec_curve_pkg::point_t            o_p,
  output logic                            o_done,
  output logic                            o_busy
);
  import ec_curve_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} state_t;

  state_t            state;
  point_t            q, n;
  logic [K_BITS-1:0] k;
  logic              add_pend, dbl_pend;
  // Doubling of N was launched in this bit
  logic              dbl_used;
  // Next doubler result also becomes Q
  logic              q_from_dbl;

  assign o_p      = q;
  assign o_add_p1 = q;
  assign o_add_p2 = n;
  assign o_dbl_p  = n;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= S_IDLE;
      k          <= '0;
      o_busy     <= 1'b0;
      o_done     <= 1'b0;
      o_dbl_go   <= 1'b0;
      o_add_go   <= 1'b0;
      add_pend   <= 1'b0;
      dbl_pend   <= 1'b0;
      dbl_used   <= 1'b0;
      q_from_dbl <= 1'b0;
    end else begin
      o_done   <= 1'b0;
      o_dbl_go <= 1'b0;
      o_add_go <= 1'b0;
      if (o_done) begin
        o_busy <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          dbl_used   <= 1'b0;
          q_from_dbl <= 1'b0;
          if (!o_busy && i_start) begin
            // Q starts at infinity
            q      <= '0;
            n      <= i_p;
            k      <= i_k;
            o_busy <= 1'b1;
            state  <= S_ISSUE;
          end else if (!o_busy && i_add_start) begin
            // Direct add is a single pass with no scalar bits left
            q        <= i_p;
            n        <= i_p2;
            k        <= '0;
            o_busy   <= 1'b1;
            o_add_go <= 1'b1;
            add_pend <= 1'b1;
            state    <= S_WAIT;
          end
        end
        S_ISSUE: begin
          q_from_dbl <= 1'b0;
          if (k == '0) begin
            o_done <= 1'b1;
            state  <= S_IDLE;
          end else begin
            o_add_go <= k[0];
            add_pend <= k[0];
            // No doubling needed once the remaining bits are zero
            o_dbl_go <= |k[K_BITS-1:1];
            dbl_pend <= |k[K_BITS-1:1];
            dbl_used <= |k[K_BITS-1:1];
            k        <= k >> 1;
            state    <= S_WAIT;
          end
        end
        default: begin
          if (i_add_done) begin
            add_pend <= 1'b0;
            q        <= i_add_p;
          end
          // Q == N, so Q + N is the doubling of N
          if (i_add_same) begin
            add_pend <= 1'b0;
            if (!dbl_used) begin
              o_dbl_go   <= 1'b1;
              dbl_pend   <= 1'b1;
              q_from_dbl <= 1'b1;
            end else if (dbl_pend && !i_dbl_done) begin
              q_from_dbl <= 1'b1;
            end else if (!dbl_pend) begin
              q <= n;
            end
          end
          if (i_dbl_done) begin
            dbl_pend <= 1'b0;
            n        <= i_dbl_p;
            if (q_from_dbl || (i_add_same && dbl_used)) begin
              q <= i_dbl_p;
            end
          end
          if (!add_pend && !dbl_pend) begin
            state <= S_ISSUE;
          end
        end
      endcase
    end
  end

  // A unit is not started again before it reports back
  assert property (@(posedge i_clk) disable iff (i_rst)
    o_dbl_go |=> !o_dbl_go until i_dbl_done);
  assert property (@(posedge i_clk) disable iff (i_rst)
    o_add_go |=> !o_add_go until (i_add_done || i_add_same));

endmodule

// ==== verilog/ec_point_mult.sv ====
//======================================================================
// Elliptic curve point multiplier
//======================================================================
module ec_point_mult (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_start,
  input  logic                            i_add_start,
  input  logic [ec_curve_pkg::K_BITS-1:0] i_k,
  input  ec_curve_pkg::point_t            i_p,
  input  ec_curve_pkg::point_t            i_p2,
  output ec_curve_pkg::point_t            o_p,
  output logic                            o_done,
  output logic                            o_busy
);
  import ec_field_pkg::*;
  import ec_curve_pkg::*;

  point_t     dbl_p_in, dbl_p_out, add_p1, add_p2, add_p_out;
  logic       dbl_go, dbl_done, add_go, add_done, add_same;
  // Index 0 is the doubler, index 1 the adder
  logic [1:0] mreq, mgnt, mrval;
  fe_t        dbl_ma, dbl_mb, add_ma, add_mb;
  fe_t        arb_a, arb_b, mul_res, arb_res;
  logic       arb_val, arb_tag, mul_val, mul_tag;

  point_mult_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (i_start),
    .i_add_start (i_add_start),
    .i_k         (i_k),
    .i_p         (i_p),
    .i_p2        (i_p2),
    .o_dbl_go    (dbl_go),
    .o_dbl_p     (dbl_p_in),
    .i_dbl_done  (dbl_done),
    .i_dbl_p     (dbl_p_out),
    .o_add_go    (add_go),
    .o_add_p1    (add_p1),
    .o_add_p2    (add_p2),
    .i_add_done  (add_done),
    .i_add_same  (add_same),
    .i_add_p     (add_p_out),
    .o_p         (o_p),
    .o_done      (o_done),
    .o_busy      (o_busy)
  );

  point_dbl u_dbl (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_go   (dbl_go),
    .i_p    (dbl_p_in),
    .o_p    (dbl_p_out),
    .o_done (dbl_done),
    .o_mreq (mreq[0]),
    .o_ma   (dbl_ma),
    .o_mb   (dbl_mb),
    .i_mgnt (mgnt[0]),
    .i_mval (mrval[0]),
    .i_mres (arb_res)
  );

  point_add u_add (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_go   (add_go),
    .i_p1   (add_p1),
    .i_p2   (add_p2),
    .o_p    (add_p_out),
    .o_done (add_done),
    .o_same (add_same),
    .o_mreq (mreq[1]),
    .o_ma   (add_ma),
    .o_mb   (add_mb),
    .i_mgnt (mgnt[1]),
    .i_mval (mrval[1]),
    .i_mres (arb_res)
  );

  mult_arbiter u_arb (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_req  (mreq),
    .i_a0   (dbl_ma),
    .i_b0   (dbl_mb),
    .i_a1   (add_ma),
    .i_b1   (add_mb),
    .o_gnt  (mgnt),
    .o_val  (arb_val),
    .o_a    (arb_a),
    .o_b    (arb_b),
    .o_tag  (arb_tag),
    .i_val  (mul_val),
    .i_res  (mul_res),
    .i_tag  (mul_tag),
    .o_rval (mrval),
    .o_res  (arb_res)
  );

  fp_mult u_mult (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (arb_val),
    .i_a   (arb_a),
    .i_b   (arb_b),
    .i_tag (arb_tag),
    .o_val (mul_val),
    .o_res (mul_res),
    .o_tag (mul_tag)
  );

endmodule

// ==== testbench/ec_ref_model.sv ====
//======================================================================
// Reference field and curve model
//======================================================================
package ec_ref_model;
  import ec_field_pkg::*;
  import ec_curve_pkg::*;

  localparam int CURVE_B = 7;

  // Affine point, inf marks the point at infinity
  typedef struct packed {
    bit inf;
    int x;
    int y;
  } aff_t;

  localparam aff_t INF = '{inf: 1'b1, x: 0, y: 0};

  function automatic int mod_add(int a, int b);
    return (a + b) % P;
  endfunction

  function automatic int mod_sub(int a, int b);
    return (a - b + P) % P;
  endfunction

  function automatic int mod_mul(int a, int b);
    return (a * b) % P;
  endfunction

  function automatic int mod_pow(int a, int e);
    int r;
    int b;
    r = 1;
    b = a % P;
    while (e > 0) begin
      if ((e & 1) != 0) begin
        r = mod_mul(r, b);
      end
      b = mod_mul(b, b);
      e = e >> 1;
    end
    return r;
  endfunction

  // Fermat inverse
  function automatic int mod_inv(int a);
    return mod_pow(a, P - 2);
  endfunction

  // P = 3 mod 4, so a root is a^((P+1)/4) when one exists
  function automatic int mod_sqrt(int a);
    return mod_pow(a, (P + 1) / 4);
  endfunction

  function automatic int curve_rhs(int x);
    return mod_add(mod_add(mod_mul(mod_mul(x, x), x), mod_mul(int'(CURVE_A), x)), CURVE_B);
  endfunction

  function automatic aff_t aff_dbl(aff_t p);
    aff_t r;
    int   lam;
    r = INF;
    if (p.inf || p.y == 0) begin
      return r;
    end
    lam = mod_mul(mod_add(mod_mul(3, mod_mul(p.x, p.x)), int'(CURVE_A)),
                  mod_inv(mod_add(p.y, p.y)));
    r.inf = 1'b0;
    r.x = mod_sub(mod_mul(lam, lam), mod_add(p.x, p.x));
    r.y = mod_sub(mod_mul(lam, mod_sub(p.x, r.x)), p.y);
    return r;
  endfunction

  function automatic aff_t aff_add(aff_t p, aff_t q);
    aff_t r;
    int   lam;
    r = INF;
    if (p.inf) begin
      return q;
    end
    if (q.inf) begin
      return p;
    end
    if (p.x == q.x) begin
      // Either the negation or the same point
      return (mod_add(p.y, q.y) == 0) ? r : aff_dbl(p);
    end
    lam = mod_mul(mod_sub(q.y, p.y), mod_inv(mod_sub(q.x, p.x)));
    r.inf = 1'b0;
    r.x = mod_sub(mod_sub(mod_mul(lam, lam), p.x), q.x);
    r.y = mod_sub(mod_mul(lam, mod_sub(p.x, r.x)), p.y);
    return r;
  endfunction

  function automatic aff_t aff_mul(int k, aff_t p);
    aff_t r;
    aff_t n;
    r = INF;
    n = p;
    for (int i = 0; i < K_BITS; i++) begin
      if (((k >> i) & 1) != 0) begin
        r = aff_add(r, n);
      end
      n = aff_dbl(n);
    end
    return r;
  endfunction

endpackage

// ==== testbench/ec_mult_tb.sv ====
//======================================================================
// Point multiplier testbench
//======================================================================
module ec_mult_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ec_field_pkg::*;
  import ec_curve_pkg::*;
  import ec_ref_model::*;

  localparam int N_RAND     = 8;
  localparam int N_TESTS    = N_RAND + 5;
  localparam int MAX_CYCLES = N_TESTS * K_BITS * 200;

  logic              i_clk;
  logic              i_rst;
  logic              i_start;
  logic              i_add_start;
  logic [K_BITS-1:0] i_k;
  point_t            i_p;
  point_t            i_p2;
  point_t            o_p;
  logic              o_done;
  logic              o_busy;

  logic [31:0] lfsr_q;
  int          cycles = 0;
  int          value_errs = 0;
  int          curve_errs = 0;
  int          proto_errs = 0;
  int          starts_sent = 0;
  int          dones_seen = 0;
  // Expected result in affine form
  bit          exp_inf = 1'b1;
  int          exp_x = 0;
  int          exp_y = 0;

  ec_point_mult UUT (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (i_start),
    .i_add_start (i_add_start),
    .i_k         (i_k),
    .i_p         (i_p),
    .i_p2        (i_p2),
    .o_p         (o_p),
    .o_done      (o_done),
    .o_busy      (o_busy)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic int random_z();
    return 1 + int'(rand_bits(FE_BITS)) % (P - 1);
  endfunction

  function automatic point_t to_jac(aff_t a, int z);
    point_t j;
    int     z2;
    z2 = mod_mul(z, z);
    j.x = fe_t'(mod_mul(a.x, z2));
    j.y = fe_t'(mod_mul(a.y, mod_mul(z2, z)));
    j.z = a.inf ? '0 : fe_t'(z);
    return j;
  endfunction

  // X == x*Z^2 and Y == y*Z^3, or Z == 0 for infinity
  function automatic bit jac_matches(point_t j, bit inf, int x, int y);
    int z;
    int z2;
    z = int'(j.z);
    z2 = mod_mul(z, z);
    if (inf) begin
      return z == 0;
    end
    return z != 0 && int'(j.x) == mod_mul(x, z2) && int'(j.y) == mod_mul(y, mod_mul(z2, z));
  endfunction

  function automatic bit jac_on_curve(point_t j);
    int x;
    int z2;
    int z4;
    int rhs;
    x = int'(j.x);
    z2 = mod_mul(int'(j.z), int'(j.z));
    z4 = mod_mul(z2, z2);
    rhs = mod_add(mod_mul(mod_mul(x, x), x),
                  mod_add(mod_mul(mod_mul(int'(CURVE_A), x), z4),
                          mod_mul(CURVE_B, mod_mul(z4, z2))));
    return mod_mul(int'(j.y), int'(j.y)) == rhs;
  endfunction

  // Try x values until the right-hand side has a square root
  task automatic random_point(output aff_t pt);
    int x;
    int rhs;
    int y;
    bit found;
    found = 1'b0;
    while (!found) begin
      x = int'(rand_bits(FE_BITS)) % P;
      rhs = curve_rhs(x);
      y = mod_sqrt(rhs);
      found = (mod_mul(y, y) == rhs);
    end
    pt.inf = 1'b0;
    pt.x = x;
    pt.y = y;
  endtask

  task automatic set_expected(aff_t e);
    exp_inf = e.inf;
    exp_x = e.x;
    exp_y = e.y;
  endtask

  task automatic wait_done(bit poke);
    while (!o_done) begin
      @(negedge i_clk);
    end
    if (poke) begin
      // o_busy is still high in the result cycle
      i_start = 1'b1;
      i_add_start = 1'b1;
    end
    // Hold the expected value over the edge that checks it
    @(negedge i_clk);
    i_start = 1'b0;
    i_add_start = 1'b0;
  endtask

  task automatic run_mult(logic [K_BITS-1:0] k, aff_t p, bit poke, bit both);
    set_expected(aff_mul(int'(k), p));
    i_k = k;
    i_p = to_jac(p, random_z());
    i_p2 = i_p;
    i_start = 1'b1;
    i_add_start = both;
    starts_sent++;
    @(negedge i_clk);
    i_start = 1'b0;
    i_add_start = 1'b0;
    if (poke) begin
      // A second command while busy must leave no trace
      i_k = ~k;
      i_start = 1'b1;
      i_add_start = 1'b1;
      @(negedge i_clk);
      i_start = 1'b0;
      i_add_start = 1'b0;
    end
    wait_done(poke);
  endtask

  task automatic run_add(aff_t a, aff_t b);
    set_expected(aff_add(a, b));
    i_p = to_jac(a, random_z());
    i_p2 = to_jac(b, random_z());
    i_add_start = 1'b1;
    starts_sent++;
    @(negedge i_clk);
    i_add_start = 1'b0;
    wait_done(1'b0);
  endtask

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (!i_rst && o_done) begin
      dones_seen <= dones_seen + 1;
    end
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  assert property (@(posedge i_clk) i_rst |=> (!o_done && !o_busy))
    else begin
      proto_errs++;
      $display("[FAIL] o_done=%h o_busy=%h after reset", o_done, o_busy);
    end

  assert property (@(posedge i_clk) disable iff (i_rst)
    o_done |-> jac_matches(o_p, exp_inf, exp_x, exp_y))
    else begin
      value_errs++;
      $display("[FAIL] o_p X=%h Y=%h Z=%h, expected x=%h y=%h inf=%h",
               o_p.x, o_p.y, o_p.z, exp_x, exp_y, exp_inf);
    end

  assert property (@(posedge i_clk) disable iff (i_rst)
    (o_done && o_p.z != '0) |-> jac_on_curve(o_p))
    else begin
      curve_errs++;
      $display("[FAIL] o_p X=%h Y=%h Z=%h is not on the curve", o_p.x, o_p.y, o_p.z);
    end

  assert property (@(posedge i_clk) disable iff (i_rst)
    o_done |-> (dones_seen < starts_sent))
    else begin
      proto_errs++;
      $display("Result strobe without a matching accepted start");
    end

  assert property (@(posedge i_clk) disable iff (i_rst)
    ((i_start || i_add_start) && !o_busy) |=> o_busy)
    else begin
      proto_errs++;
      $display("o_busy did not rise after an accepted start");
    end

  initial begin
    aff_t base;
    aff_t other;
    aff_t neg;
    i_rst = 1'b1;
    i_start = 1'b0;
    i_add_start = 1'b0;
    i_k = '0;
    i_p = '0;
    i_p2 = '0;
    lfsr_q = 32'h860f_093b;
    repeat (4) @(negedge i_clk);
    i_rst = 1'b0;
    @(negedge i_clk);

    for (int t = 0; t < N_RAND; t++) begin
      random_point(base);
      run_mult(K_BITS'(rand_bits(K_BITS)), base, t == 0, 1'b0);
    end

    // k = 0 and k = 1, the latter with both strobes at once
    random_point(base);
    run_mult('0, base, 1'b0, 1'b0);
    run_mult(K_BITS'(1), base, 1'b0, 1'b1);

    random_point(other);
    run_add(base, other);
    run_add(base, base);
    neg = base;
    neg.y = mod_sub(0, base.y);
    run_add(base, neg);

    assert (starts_sent == dones_seen)
      else begin
        proto_errs++;
        $display("%0d starts were accepted but %0d results came back", starts_sent, dones_seen);
      end
    $display("Errors: value %0d, curve %0d, protocol %0d", value_errs, curve_errs, proto_errs);
    if (value_errs + curve_errs + proto_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/ec_field_pkg.sv
verilog/ec_curve_pkg.sv
verilog/fp_mult.sv
verilog/mult_arbiter.sv
verilog/point_dbl.sv
verilog/point_add.sv
verilog/point_mult_ctrl.sv
verilog/ec_point_mult.sv
testbench/ec_ref_model.sv
testbench/ec_mult_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ec_mult_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)/obj
	./$(BUILD_DIR)/obj/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
